//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word and address widths
`define CPU_DATA_W   32
`define CPU_ADDR_W   32

// Architectural register file
`define CPU_REG_NUM  32
`define CPU_REG_AW   5

// Primary opcodes
`define OP_SPECIAL   6'b000000
`define OP_ADDIU     6'b001001
`define OP_SLTI      6'b001010
`define OP_ANDI      6'b001100
`define OP_ORI       6'b001101
`define OP_XORI      6'b001110
`define OP_LUI       6'b001111

// Function codes under SPECIAL
`define FN_SLL       6'b000000
`define FN_ADDU      6'b100001
`define FN_SUBU      6'b100011
`define FN_AND       6'b100100
`define FN_OR        6'b100101
`define FN_XOR       6'b100110
`define FN_NOR       6'b100111
`define FN_SLT       6'b101010

`endif

//--- sim/inst_rom.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module inst_rom (
	input  logic                   ce_i,
	input  logic [`CPU_ADDR_W-1:0] addr_i,
	output logic [`CPU_DATA_W-1:0] data_o
);

	localparam int DEPTH = 1024;

	logic [`CPU_DATA_W-1:0] mem [DEPTH];

	// Word addressed, anything past the array reads as zero
	always_comb begin
		if (!ce_i) begin
			data_o = '0;
		end else if (addr_i[`CPU_ADDR_W-1:2] >= DEPTH) begin
			data_o = '0;
		end else begin
			data_o = mem[addr_i[11:2]];
		end
	end

	task automatic clear_all();
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	endtask

	task automatic write_word(input int index, input logic [`CPU_DATA_W-1:0] word);
		mem[index] = word;
	endtask

endmodule

//--- sim/tb_cpu.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module tb_cpu;

	import cpu_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 5;
	localparam int DRAIN_CYCLES  = 4;
	localparam int NUM_TESTS     = 5;
	localparam int RANDOM_LEN    = 300;
	// Upper bound on all programs together
	localparam int INST_BUDGET   = 560;
	localparam int TEST_OVERHEAD = 24;
	localparam int WATCHDOG_NS   =
		(INST_BUDGET * 2 + NUM_TESTS * (RESET_CYCLES + TEST_OVERHEAD)) * CLK_PERIOD;
	localparam int COMMIT_LAT    = 3;

	localparam logic [5:0] R_FUNCTS [8] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR,
		`FN_XOR, `FN_NOR, `FN_SLT, `FN_SLL};
	localparam logic [5:0] I_OPS [6] = '{`OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI,
		`OP_XORI, `OP_LUI};

	logic                   clk;
	logic                   rst_n;
	logic [`CPU_DATA_W-1:0] rom_data;
	logic                   rom_ce;
	logic [`CPU_ADDR_W-1:0] rom_addr;
	logic                   wb_we;
	logic [`CPU_REG_AW-1:0] wb_waddr;
	logic [`CPU_DATA_W-1:0] wb_wdata;

	// Program image and expected commits as {waddr, wdata}
	logic [`CPU_DATA_W-1:0]             prog [$];
	logic [`CPU_REG_AW+`CPU_DATA_W-1:0] exp_q [$];
	logic [`CPU_REG_AW+`CPU_DATA_W-1:0] exp_entry;
	logic [`CPU_DATA_W-1:0]             model_regs [`CPU_REG_NUM];

	int seed;
	int errors;
	int test_errors_base;
	int tests_run;
	int tests_failed;

	cpu dut0 (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.rom_data_i (rom_data),
		.rom_ce_o   (rom_ce),
		.rom_addr_o (rom_addr),
		.wb_we_o    (wb_we),
		.wb_waddr_o (wb_waddr),
		.wb_wdata_o (wb_wdata)
	);

	inst_rom rom0 (
		.ce_i   (rom_ce),
		.addr_i (rom_addr),
		.data_o (rom_data)
	);

	initial begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		inst_u w;
		w.r.op    = `OP_SPECIAL;
		w.r.rs    = rs;
		w.r.rt    = rt;
		w.r.rd    = rd;
		w.r.shamt = shamt;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		inst_u w;
		w.i.op  = op;
		w.i.rs  = rs;
		w.i.rt  = rt;
		w.i.imm = imm;
		return w;
	endfunction

	// ISA semantics of one instruction against the model registers
	function automatic void reference_step(
		input  logic [31:0] word,
		input  logic [31:0] regs [`CPU_REG_NUM],
		output logic        we,
		output logic [4:0]  addr,
		output logic [31:0] data
	);
		inst_u       w;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [31:0] sext;
		logic [31:0] zext;
		w      = word;
		rs_val = regs[w.r.rs];
		rt_val = regs[w.r.rt];
		sext   = {{16{w.i.imm[15]}}, w.i.imm};
		zext   = {16'h0000, w.i.imm};
		we     = 1'b1;
		addr   = w.i.rt;
		data   = '0;
		case (w.r.op)
			`OP_SPECIAL: begin
				addr = w.r.rd;
				case (w.r.funct)
					`FN_SLL:  data = rt_val << w.r.shamt;
					`FN_ADDU: data = rs_val + rt_val;
					`FN_SUBU: data = rs_val - rt_val;
					`FN_AND:  data = rs_val & rt_val;
					`FN_OR:   data = rs_val | rt_val;
					`FN_XOR:  data = rs_val ^ rt_val;
					`FN_NOR:  data = ~(rs_val | rt_val);
					`FN_SLT:  data = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
					default:  we = 1'b0;
				endcase
			end
			`OP_ADDIU: data = rs_val + sext;
			`OP_SLTI:  data = ($signed(rs_val) < $signed(sext)) ? 32'd1 : 32'd0;
			`OP_ANDI:  data = rs_val & zext;
			`OP_ORI:   data = rs_val | zext;
			`OP_XORI:  data = rs_val ^ zext;
			`OP_LUI:   data = {w.i.imm, 16'h0000};
			default:   we = 1'b0;
		endcase
		// r0 is hardwired to zero
		if (addr == 5'd0) begin
			we = 1'b0;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic add_inst(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic build_expected();
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
		for (int i = 0; i < `CPU_REG_NUM; i++) begin
			model_regs[i] = '0;
		end
		exp_q.delete();
		foreach (prog[i]) begin
			reference_step(prog[i], model_regs, we, addr, data);
			if (we) begin
				model_regs[addr] = data;
				exp_q.push_back({addr, data});
			end
		end
	endtask

	// Reset, load the ROM while in reset, then release
	task automatic start_program();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		rom0.clear_all();
		foreach (prog[i]) begin
			rom0.write_word(i, prog[i]);
		end
		build_expected();
		test_errors_base = errors;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value("rom_ce_o", 32'(rom_ce), 32'd0);
			check_value("wb_we_o", 32'(wb_we), 32'd0);
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic finish_program(input string name);
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < prog.size() + TEST_OVERHEAD) begin
			@(posedge clk);
			waited++;
		end
		// Catch any commit past the last expected one
		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("ERROR %0t ns: %0d expected commits never arrived", $time, exp_q.size());
			errors++;
		end
		tests_run++;
		if (errors == test_errors_base) begin
			$display("test %s: ok, %0d instructions", name, prog.size());
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_errors_base);
		end
	endtask

	// Fetch starts on the first edge after release and each word commits three cycles later
	task automatic check_fetch_sequence(input int cycles, input int commits);
		@(negedge clk);
		check_value("rom_ce_o", 32'(rom_ce), 32'd0);
		for (int k = 0; k < cycles; k++) begin
			@(negedge clk);
			check_value("rom_ce_o", 32'(rom_ce), 32'd1);
			check_value("rom_addr_o", rom_addr, 32'(4 * k));
			check_value("wb_we_o", 32'(wb_we),
				(k >= COMMIT_LAT && k < COMMIT_LAT + commits) ? 32'd1 : 32'd0);
		end
	endtask

	// Commit stream against the expected queue
	always @(negedge clk) begin
		if (rst_n && wb_we) begin
			if (exp_q.size() == 0) begin
				$display("ERROR %0t ns: commit to r%0d arrived with none expected",
					$time, wb_waddr);
				errors++;
			end else begin
				exp_entry = exp_q.pop_front();
				check_value("wb_waddr_o", 32'(wb_waddr),
					32'(exp_entry[`CPU_DATA_W +: `CPU_REG_AW]));
				check_value("wb_wdata_o", wb_wdata, exp_entry[`CPU_DATA_W-1:0]);
			end
		end
	end

	task automatic reset_and_fetch();
		prog.delete();
		add_inst(itype_word(`OP_ORI, 5'd1, 5'd0, 16'h00a5));
		add_inst(itype_word(`OP_LUI, 5'd2, 5'd0, 16'h5a5a));
		add_inst(rtype_word(`FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
		add_inst(rtype_word(`FN_XOR, 5'd4, 5'd3, 5'd1, 5'd0));
		start_program();
		// Every word here writes a nonzero register
		check_fetch_sequence(16, prog.size());
		finish_program("reset_and_fetch");
	endtask

	task automatic immediate_ops();
		prog.delete();
		add_inst(itype_word(`OP_ADDIU, 5'd1, 5'd0, 16'hfffb));
		add_inst(itype_word(`OP_ADDIU, 5'd2, 5'd1, 16'h8000));
		add_inst(itype_word(`OP_ANDI, 5'd3, 5'd1, 16'hf0f0));
		add_inst(itype_word(`OP_ORI, 5'd4, 5'd0, 16'h8001));
		add_inst(itype_word(`OP_XORI, 5'd5, 5'd1, 16'hffff));
		add_inst(itype_word(`OP_SLTI, 5'd6, 5'd1, 16'hfffc));
		add_inst(itype_word(`OP_SLTI, 5'd7, 5'd1, 16'hfffa));
		add_inst(itype_word(`OP_SLTI, 5'd8, 5'd4, 16'h7fff));
		add_inst(itype_word(`OP_LUI, 5'd9, 5'd0, 16'h8765));
		// lui ignores rs
		add_inst(itype_word(`OP_LUI, 5'd10, 5'd7, 16'h1234));
		add_inst(itype_word(`OP_ORI, 5'd10, 5'd10, 16'h5678));
		add_inst(itype_word(`OP_ADDIU, 5'd31, 5'd9, 16'h0001));
		start_program();
		finish_program("immediate_ops");
	endtask

	// Producer then consumer at distance 1, 2 and 3 on each read port
	task automatic dependency_chains();
		logic [4:0] dst;
		prog.delete();
		add_inst(itype_word(`OP_LUI, 5'd1, 5'd0, 16'h8000));
		add_inst(itype_word(`OP_ORI, 5'd1, 5'd1, 16'h0013));
		add_inst(itype_word(`OP_ADDIU, 5'd2, 5'd0, 16'h0123));
		add_inst(itype_word(`OP_ADDIU, 5'd3, 5'd0, 16'hfff9));
		for (int d = 1; d <= 3; d++) begin
			for (int p = 0; p < 2; p++) begin
				foreach (R_FUNCTS[i]) begin
					dst = (p == 0) ? 5'd10 : 5'd13;
					add_inst(rtype_word(R_FUNCTS[i], dst, 5'd1, 5'd2, 5'(4 + d)));
					for (int j = 1; j < d; j++) begin
						add_inst(itype_word(`OP_ADDIU, 5'(19 + j), 5'd3, 16'(j)));
					end
					if (p == 0) begin
						add_inst(rtype_word(R_FUNCTS[i], 5'd11, dst, 5'd3, 5'd3));
					end else begin
						add_inst(rtype_word(R_FUNCTS[i], 5'd14, 5'd3, dst, 5'd3));
					end
				end
			end
		end
		start_program();
		finish_program("dependency_chains");
	endtask

	task automatic r0_and_undefined();
		prog.delete();
		add_inst(itype_word(`OP_ADDIU, 5'd1, 5'd0, 16'h0021));
		add_inst(itype_word(`OP_ADDIU, 5'd0, 5'd0, 16'h0037));
		add_inst(itype_word(`OP_ADDIU, 5'd2, 5'd0, 16'h0001));
		add_inst(rtype_word(`FN_ADDU, 5'd0, 5'd1, 5'd1, 5'd0));
		add_inst(rtype_word(`FN_OR, 5'd3, 5'd0, 5'd1, 5'd0));
		add_inst(itype_word(`OP_ORI, 5'd0, 5'd1, 16'hffff));
		add_inst(rtype_word(`FN_NOR, 5'd4, 5'd0, 5'd0, 5'd0));
		// A load, a jr and an unknown opcode
		add_inst(itype_word(6'b100011, 5'd1, 5'd0, 16'h0004));
		add_inst(rtype_word(6'b001000, 5'd1, 5'd2, 5'd0, 5'd0));
		add_inst(itype_word(6'b111111, 5'd5, 5'd1, 16'h1111));
		add_inst(rtype_word(`FN_ADDU, 5'd6, 5'd1, 5'd0, 5'd0));
		add_inst(rtype_word(`FN_ADDU, 5'd9, 5'd5, 5'd1, 5'd0));
		add_inst(rtype_word(`FN_SLL, 5'd0, 5'd0, 5'd1, 5'd2));
		add_inst(rtype_word(`FN_ADDU, 5'd7, 5'd0, 5'd0, 5'd0));
		add_inst(rtype_word(`FN_SUBU, 5'd8, 5'd0, 5'd1, 5'd0));
		start_program();
		finish_program("r0_and_undefined");
	endtask

	// Registers drawn from r0..r7 so that hazards are frequent
	task automatic add_random_inst();
		int          kind;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  sh;
		logic [15:0] imm;
		kind = $unsigned($random(seed)) % 14;
		rd   = 5'(3'($random(seed)));
		rs   = 5'(3'($random(seed)));
		rt   = 5'(3'($random(seed)));
		sh   = 5'($random(seed));
		imm  = 16'($random(seed));
		if (kind < 8) begin
			if (R_FUNCTS[kind] != `FN_SLL) begin
				sh = 5'd0;
			end
			add_inst(rtype_word(R_FUNCTS[kind], rd, rs, rt, sh));
		end else begin
			add_inst(itype_word(I_OPS[kind - 8], rt, rs, imm));
		end
	endtask

	task automatic random_stream();
		prog.delete();
		for (int n = 0; n < RANDOM_LEN; n++) begin
			add_random_inst();
		end
		start_program();
		finish_program("random_stream");
	endtask

	initial begin
		rst_n            = 1'b0;
		seed             = 3;
		errors           = 0;
		test_errors_base = 0;
		tests_run        = 0;
		tests_failed     = 0;
		reset_and_fetch();
		immediate_ops();
		dependency_chains();
		r0_and_undefined();
		random_stream();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/regfile.sv
src/exec_stage.sv
src/cpu.sv
sim/inst_rom.sv
sim/tb_cpu.sv

//--- src/cpu.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [`CPU_DATA_W-1:0] rom_data_i,
	output logic                   rom_ce_o,
	output logic [`CPU_ADDR_W-1:0] rom_addr_o,
	output logic                   wb_we_o,
	output logic [`CPU_REG_AW-1:0] wb_waddr_o,
	output logic [`CPU_DATA_W-1:0] wb_wdata_o
);

	import cpu_pkg::*;

	// Fetch to decode
	logic [`CPU_DATA_W-1:0] id_inst;
	logic                   id_valid;

	// Register file read ports
	logic [`CPU_REG_AW-1:0] rf_raddr1;
	logic [`CPU_REG_AW-1:0] rf_raddr2;
	logic [`CPU_DATA_W-1:0] rf_rdata1;
	logic [`CPU_DATA_W-1:0] rf_rdata2;

	// Decode to execute
	alu_op_e                ex_op;
	logic [`CPU_DATA_W-1:0] ex_src1;
	logic [`CPU_DATA_W-1:0] ex_src2;
	logic [4:0]             ex_shamt;
	logic                   ex_we;
	logic [`CPU_REG_AW-1:0] ex_waddr;
	logic [`CPU_DATA_W-1:0] ex_res;

	fetch_stage fetch0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_data_i (rom_data_i),
		.rom_ce_o   (rom_ce_o),
		.rom_addr_o (rom_addr_o),
		.id_inst_o  (id_inst),
		.id_valid_o (id_valid)
	);

	// Execute result and writeback register feed back into decode
	decode_stage decode0 (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.id_inst_i      (id_inst),
		.id_valid_i     (id_valid),
		.rf_raddr1_o    (rf_raddr1),
		.rf_raddr2_o    (rf_raddr2),
		.rf_rdata1_i    (rf_rdata1),
		.rf_rdata2_i    (rf_rdata2),
		.ex_fwd_we_i    (ex_we),
		.ex_fwd_waddr_i (ex_waddr),
		.ex_fwd_wdata_i (ex_res),
		.wb_fwd_we_i    (wb_we_o),
		.wb_fwd_waddr_i (wb_waddr_o),
		.wb_fwd_wdata_i (wb_wdata_o),
		.ex_op_o        (ex_op),
		.ex_src1_o      (ex_src1),
		.ex_src2_o      (ex_src2),
		.ex_shamt_o     (ex_shamt),
		.ex_we_o        (ex_we),
		.ex_waddr_o     (ex_waddr)
	);

	exec_stage exec0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.op_i       (ex_op),
		.src1_i     (ex_src1),
		.src2_i     (ex_src2),
		.shamt_i    (ex_shamt),
		.we_i       (ex_we),
		.waddr_i    (ex_waddr),
		.res_o      (ex_res),
		.wb_we_o    (wb_we_o),
		.wb_waddr_o (wb_waddr_o),
		.wb_wdata_o (wb_wdata_o)
	);

	regfile regfile0 (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.we_i     (wb_we_o),
		.waddr_i  (wb_waddr_o),
		.wdata_i  (wb_wdata_o),
		.raddr1_i (rf_raddr1),
		.raddr2_i (rf_raddr2),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2)
	);

endmodule

//--- src/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

	// R-format fields
	typedef struct packed {
		logic [5:0]             op;
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] rd;
		logic [4:0]             shamt;
		logic [5:0]             funct;
	} r_fmt_t;

	// I-format fields
	typedef struct packed {
		logic [5:0]             op;
		logic [`CPU_REG_AW-1:0] rs;
		logic [`CPU_REG_AW-1:0] rt;
		logic [15:0]            imm;
	} i_fmt_t;

	// One instruction word, two views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_u;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_e;

endpackage

//--- src/decode_stage.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [`CPU_DATA_W-1:0] id_inst_i,
	input  logic                   id_valid_i,
	output logic [`CPU_REG_AW-1:0] rf_raddr1_o,
	output logic [`CPU_REG_AW-1:0] rf_raddr2_o,
	input  logic [`CPU_DATA_W-1:0] rf_rdata1_i,
	input  logic [`CPU_DATA_W-1:0] rf_rdata2_i,
	input  logic                   ex_fwd_we_i,
	input  logic [`CPU_REG_AW-1:0] ex_fwd_waddr_i,
	input  logic [`CPU_DATA_W-1:0] ex_fwd_wdata_i,
	input  logic                   wb_fwd_we_i,
	input  logic [`CPU_REG_AW-1:0] wb_fwd_waddr_i,
	input  logic [`CPU_DATA_W-1:0] wb_fwd_wdata_i,
	output cpu_pkg::alu_op_e       ex_op_o,
	output logic [`CPU_DATA_W-1:0] ex_src1_o,
	output logic [`CPU_DATA_W-1:0] ex_src2_o,
	output logic [4:0]             ex_shamt_o,
	output logic                   ex_we_o,
	output logic [`CPU_REG_AW-1:0] ex_waddr_o
);

	import cpu_pkg::*;

	inst_u                  inst;
	alu_op_e                dec_op;
	logic                   dec_legal;
	logic                   dec_we;
	logic [`CPU_REG_AW-1:0] dec_waddr;
	logic [4:0]             dec_shamt;
	logic                   use_imm;
	logic [`CPU_DATA_W-1:0] imm_ext;
	logic [`CPU_DATA_W-1:0] op1;
	logic [`CPU_DATA_W-1:0] op2_reg;

	// Newest producer wins: execute, then writeback, then the array
	function automatic logic [`CPU_DATA_W-1:0] resolve(
		input logic [`CPU_REG_AW-1:0] addr,
		input logic [`CPU_DATA_W-1:0] rf_val
	);
		if (ex_fwd_we_i && ex_fwd_waddr_i == addr)
			return ex_fwd_wdata_i;
		else if (wb_fwd_we_i && wb_fwd_waddr_i == addr)
			return wb_fwd_wdata_i;
		else
			return rf_val;
	endfunction

	assign inst = id_inst_i;

	// rs and rt sit at the same bits in both formats
	assign rf_raddr1_o = inst.r.rs;
	assign rf_raddr2_o = inst.r.rt;

	always_comb begin
		dec_op    = ALU_NOP;
		dec_legal = 1'b1;
		dec_waddr = inst.i.rt;
		dec_shamt = '0;
		use_imm   = 1'b1;
		imm_ext   = {{16{inst.i.imm[15]}}, inst.i.imm};
		case (inst.r.op)
			`OP_SPECIAL: begin
				dec_waddr = inst.r.rd;
				use_imm   = 1'b0;
				case (inst.r.funct)
					`FN_SLL: begin
						dec_op    = ALU_SLL;
						dec_shamt = inst.r.shamt;
					end
					`FN_ADDU: dec_op = ALU_ADD;
					`FN_SUBU: dec_op = ALU_SUB;
					`FN_AND:  dec_op = ALU_AND;
					`FN_OR:   dec_op = ALU_OR;
					`FN_XOR:  dec_op = ALU_XOR;
					`FN_NOR:  dec_op = ALU_NOR;
					`FN_SLT:  dec_op = ALU_SLT;
					default:  dec_legal = 1'b0;
				endcase
			end
			`OP_ADDIU: dec_op = ALU_ADD;
			`OP_SLTI:  dec_op = ALU_SLT;
			// Logical immediates are zero-extended
			`OP_ANDI: begin
				dec_op  = ALU_AND;
				imm_ext = {16'b0, inst.i.imm};
			end
			`OP_ORI: begin
				dec_op  = ALU_OR;
				imm_ext = {16'b0, inst.i.imm};
			end
			`OP_XORI: begin
				dec_op  = ALU_XOR;
				imm_ext = {16'b0, inst.i.imm};
			end
			`OP_LUI: begin
				dec_op  = ALU_LUI;
				imm_ext = {16'b0, inst.i.imm};
			end
			default: dec_legal = 1'b0;
		endcase
		// r0 is never written, so nothing downstream has to filter it
		dec_we = id_valid_i && dec_legal && (dec_waddr != '0);
	end

	always_comb begin
		op1     = resolve(rf_raddr1_o, rf_rdata1_i);
		op2_reg = resolve(rf_raddr2_o, rf_rdata2_i);
	end

	// ID/EX register
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_we_o <= 1'b0;
			ex_op_o <= ALU_NOP;
		end else begin
			ex_we_o <= dec_we;
			ex_op_o <= dec_op;
		end
	end

	always_ff @(posedge clk) begin
		ex_src1_o  <= op1;
		ex_src2_o  <= use_imm ? imm_ext : op2_reg;
		ex_shamt_o <= dec_shamt;
		ex_waddr_o <= dec_waddr;
	end

endmodule

//--- src/exec_stage.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module exec_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  cpu_pkg::alu_op_e       op_i,
	input  logic [`CPU_DATA_W-1:0] src1_i,
	input  logic [`CPU_DATA_W-1:0] src2_i,
	input  logic [4:0]             shamt_i,
	input  logic                   we_i,
	input  logic [`CPU_REG_AW-1:0] waddr_i,
	output logic [`CPU_DATA_W-1:0] res_o,
	output logic                   wb_we_o,
	output logic [`CPU_REG_AW-1:0] wb_waddr_o,
	output logic [`CPU_DATA_W-1:0] wb_wdata_o
);

	import cpu_pkg::*;

	logic slt_bit;

	assign slt_bit = $signed(src1_i) < $signed(src2_i);

	always_comb begin
		case (op_i)
			ALU_ADD: res_o = src1_i + src2_i;
			ALU_SUB: res_o = src1_i - src2_i;
			ALU_AND: res_o = src1_i & src2_i;
			ALU_OR:  res_o = src1_i | src2_i;
			ALU_XOR: res_o = src1_i ^ src2_i;
			ALU_NOR: res_o = ~(src1_i | src2_i);
			ALU_SLT: res_o = {{(`CPU_DATA_W-1){1'b0}}, slt_bit};
			// sll shifts rt, not rs
			ALU_SLL: res_o = src2_i << shamt_i;
			ALU_LUI: res_o = {src2_i[15:0], 16'b0};
			default: res_o = '0;
		endcase
	end

	// EX/WB register, also the commit trace
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_we_o <= 1'b0;
		end else begin
			wb_we_o <= we_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_waddr_o <= waddr_i;
		wb_wdata_o <= res_o;
	end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module fetch_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic [`CPU_DATA_W-1:0] rom_data_i,
	output logic                   rom_ce_o,
	output logic [`CPU_ADDR_W-1:0] rom_addr_o,
	output logic [`CPU_DATA_W-1:0] id_inst_o,
	output logic                   id_valid_o
);

	logic [`CPU_ADDR_W-1:0] pc;

	// Chip enable rises on the first edge after reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rom_ce_o <= 1'b0;
		end else begin
			rom_ce_o <= 1'b1;
		end
	end

	// PC holds at zero until the ROM is enabled
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc <= '0;
		end else if (!rom_ce_o) begin
			pc <= '0;
		end else begin
			pc <= pc + `CPU_ADDR_W'd4;
		end
	end

	assign rom_addr_o = pc;

	// IF/ID register, a bubble travels as an all-zero word
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_valid_o <= 1'b0;
			id_inst_o  <= '0;
		end else begin
			id_valid_o <= rom_ce_o;
			id_inst_o  <= rom_ce_o ? rom_data_i : '0;
		end
	end

endmodule

//--- src/regfile.sv
`timescale 1ns/10ps
`include "cpu_params.svh"

module regfile (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   we_i,
	input  logic [`CPU_REG_AW-1:0] waddr_i,
	input  logic [`CPU_DATA_W-1:0] wdata_i,
	input  logic [`CPU_REG_AW-1:0] raddr1_i,
	input  logic [`CPU_REG_AW-1:0] raddr2_i,
	output logic [`CPU_DATA_W-1:0] rdata1_o,
	output logic [`CPU_DATA_W-1:0] rdata2_o
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_NUM];

	// Whole array cleared on reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `CPU_REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Bypass of same-cycle writes is done by decode forwarding
	always_comb begin
		if (raddr1_i == '0) begin
			rdata1_o = '0;
		end else begin
			rdata1_o = regs[raddr1_i];
		end
	end

	always_comb begin
		if (raddr2_i == '0) begin
			rdata2_o = '0;
		end else begin
			rdata2_o = regs[raddr2_i];
		end
	end

endmodule
